/* source/aggr_pkg.sv */
// aggregation engine shared types
`default_nettype none

package aggr_pkg;

    // feature word and vector sizing
    localparam int fv_width = 16;
    localparam int max_fv_num = 8;
    localparam int node_id_width = 6;

    // two words travel per beat
    localparam int max_beats = max_fv_num / 2;
    localparam int beat_idx_width = $clog2(max_beats);
    localparam logic [beat_idx_width-1:0] last_beat_idx = beat_idx_width'(max_beats - 1);

    typedef logic [fv_width-1:0] fv_word_t;

    typedef fv_word_t [1:0] fv_pair_t;

    // from the edge PE; wb_en and done_aggr only count on the eos beat
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
        logic wb_en;
        logic done_aggr;
        logic [node_id_width-1:0] node_id;
        fv_pair_t data;
    } edge_beat_t;

    // toward the reservation station
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
        logic [node_id_width-1:0] node_id;
        fv_pair_t data;
    } rs_beat_t;

    // one row slot of the output feature memory
    typedef struct packed {
        logic valid;
        logic [node_id_width-1:0] node_id;
        logic [beat_idx_width-1:0] word_idx;
        fv_pair_t data;
    } sram_beat_t;

endpackage

`default_nettype wire

/* source/edge_dispatch.sv */
// edge beat steering to banks
`default_nettype none

module edge_dispatch #(
    parameter int num_banks = 2
) (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire aggr_pkg::edge_beat_t             edge_in,
    input  wire [num_banks-1:0]                   bank_accept,
    output logic                                  edge_ready,
    output aggr_pkg::edge_beat_t [num_banks-1:0]  bank_edge
);

    localparam int sel_width = (num_banks > 1) ? $clog2(num_banks) : 1;

    logic [sel_width-1:0] sel;
    logic [num_banks-1:0] stream_open;
    logic [aggr_pkg::node_id_width-1:0] open_node;
    logic drop;
    logic fwd;

    // bank chosen by the low bits of the node id
    assign sel = sel_width'(edge_in.node_id % num_banks);

    // beat breaking into a stream still open elsewhere, or for another node
    assign drop = (|stream_open) && !(stream_open[sel] && (open_node == edge_in.node_id));

    // dropped beats are swallowed so the source never hangs on them
    assign edge_ready = drop || bank_accept[sel];
    assign fwd = edge_in.valid && !drop && bank_accept[sel];

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            bank_edge[b] = edge_in;
            bank_edge[b].valid = edge_in.valid && !drop && (sel == b);
        end
    end

    // stream stays open from its first beat up to eos
    always_ff @(posedge clk) begin
        if (reset) begin
            stream_open <= '0;
        end else if (fwd) begin
            stream_open[sel] <= !edge_in.eos;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd) begin
            open_node <= edge_in.node_id;
        end
    end

endmodule

`default_nettype wire

/* source/edge_bank.sv */
// per-node accumulation bank
`default_nettype none

module edge_bank (
    input  wire                         clk,
    input  wire                         reset,
    input  wire aggr_pkg::edge_beat_t   edge_in,
    output logic                        accept,
    output logic                        rs_req,
    input  wire                         rs_grant,
    output aggr_pkg::rs_beat_t          rs_beat,
    output logic                        wb_req,
    input  wire                         wb_grant,
    output aggr_pkg::sram_beat_t        wb_beat
);

    localparam int idx_width = aggr_pkg::beat_idx_width;

    typedef enum logic [2:0] {
        st_idle,
        st_stream_in,
        st_complete,
        st_rs_wait,
        st_rs_out,
        st_wb_wait,
        st_wb_out
    } state_t;

    state_t state;
    aggr_pkg::fv_pair_t [aggr_pkg::max_beats-1:0] buffer;
    aggr_pkg::fv_pair_t sum;
    logic [idx_width-1:0] idx;
    logic [idx_width-1:0] in_idx;
    logic [idx_width-1:0] last_idx;
    logic [aggr_pkg::node_id_width-1:0] node_id;
    logic done_aggr;
    logic wb_en;
    logic take;

    assign accept = (state == st_idle) || (state == st_stream_in);
    assign take = accept && edge_in.valid;

    // sos always lands on slot 0
    assign in_idx = edge_in.sos ? '0 : idx;

    assign rs_req = (state == st_rs_wait);
    assign wb_req = (state == st_wb_wait);

    // element-wise add, wraps at the word width
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            sum[w] = buffer[in_idx][w] + edge_in.data[w];
        end
    end

    always_comb begin
        rs_beat = '0;
        if (state == st_rs_out) begin
            rs_beat.valid = 1'b1;
            rs_beat.sos = (idx == '0);
            rs_beat.eos = (idx == last_idx);
            rs_beat.node_id = node_id;
            rs_beat.data = buffer[idx];
        end
    end

    // write-back always covers the whole row, so no stale words survive
    always_comb begin
        wb_beat = '0;
        if (state == st_wb_out) begin
            wb_beat.valid = 1'b1;
            wb_beat.node_id = node_id;
            wb_beat.word_idx = idx;
            wb_beat.data = buffer[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            buffer <= '0;
            idx <= '0;
            last_idx <= '0;
            done_aggr <= 1'b0;
            wb_en <= 1'b0;
        end else begin
            case (state)
                st_idle, st_stream_in: begin
                    if (take) begin
                        buffer[in_idx] <= sum;
                        if (edge_in.eos) begin
                            // length and command fixed by the eos beat
                            last_idx <= in_idx;
                            done_aggr <= edge_in.done_aggr;
                            wb_en <= edge_in.wb_en;
                            idx <= '0;
                            state <= st_complete;
                        end else begin
                            idx <= in_idx + 1'b1;
                            state <= st_stream_in;
                        end
                    end
                end
                st_complete: begin
                    if (done_aggr) begin
                        state <= st_rs_wait;
                    end else if (wb_en) begin
                        state <= st_wb_wait;
                    end else begin
                        // plain end, keep summing on the next stream
                        state <= st_idle;
                    end
                end
                st_rs_wait: begin
                    if (rs_grant) begin
                        state <= st_rs_out;
                    end
                end
                st_rs_out: begin
                    if (idx == last_idx) begin
                        buffer <= '0;
                        idx <= '0;
                        state <= st_idle;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                st_wb_wait: begin
                    if (wb_grant) begin
                        state <= st_wb_out;
                    end
                end
                st_wb_out: begin
                    if (idx == aggr_pkg::last_beat_idx) begin
                        buffer <= '0;
                        idx <= '0;
                        state <= st_idle;
                    end else begin
                        idx <= idx + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // node id only matters once the stream is complete
    always_ff @(posedge clk) begin
        if (take && edge_in.eos) begin
            node_id <= edge_in.node_id;
        end
    end

endmodule

`default_nettype wire

/* source/bank_arbiter.sv */
// round-robin bank arbiter and beat mux
`default_nettype none

module bank_arbiter #(
    parameter int num_banks = 2,
    parameter type beat_t = aggr_pkg::rs_beat_t
) (
    input  wire                         clk,
    input  wire                         reset,
    input  wire [num_banks-1:0]         req,
    input  wire                         may_start,
    input  wire [num_banks-1:0]         last,
    output logic [num_banks-1:0]        grant,
    input  wire beat_t [num_banks-1:0]  beats_in,
    output beat_t                       beat_out
);

    localparam int sel_width = (num_banks > 1) ? $clog2(num_banks) : 1;

    logic busy;
    logic found;
    logic [sel_width-1:0] owner;
    logic [sel_width-1:0] pick;

    // search begins one past the last bank granted
    always_comb begin
        int c;
        pick = owner;
        found = 1'b0;
        for (int i = 1; i <= num_banks; i++) begin
            c = (int'(owner) + i) % num_banks;
            if (!found && req[c]) begin
                pick = sel_width'(c);
                found = 1'b1;
            end
        end
    end

    always_comb begin
        beat_out = beats_in[owner];
        beat_out.valid = busy && beats_in[owner].valid;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            owner <= sel_width'(num_banks - 1);
            grant <= '0;
        end else begin
            grant <= '0;
            if (!busy) begin
                if (may_start && found) begin
                    busy <= 1'b1;
                    owner <= pick;
                    grant <= num_banks'(1) << pick;
                end
            end else if (beats_in[owner].valid && last[owner]) begin
                // owner's final beat, free for the next cycle
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/output_fv_sram.sv */
// output feature memory
`default_nettype none

module output_fv_sram (
    input  wire                                     clk,
    input  wire aggr_pkg::sram_beat_t               wr_beat,
    input  wire [aggr_pkg::node_id_width-1:0]       rd_node,
    input  wire [aggr_pkg::beat_idx_width-1:0]      rd_idx,
    output aggr_pkg::fv_pair_t                      rd_data
);

    localparam int num_rows = 2 ** aggr_pkg::node_id_width;
    localparam int row_pairs = aggr_pkg::max_beats;

    // one row per node, one pair per beat slot
    aggr_pkg::fv_pair_t mem [num_rows][row_pairs];

    logic wr_hit;

    // read of the slot being written this cycle
    assign wr_hit = wr_beat.valid
                    && (wr_beat.node_id == rd_node)
                    && (wr_beat.word_idx == rd_idx);

    always_ff @(posedge clk) begin
        if (wr_beat.valid) begin
            mem[wr_beat.node_id][wr_beat.word_idx] <= wr_beat.data;
        end
    end

    // registered read, forwards a same-cycle write
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            rd_data <= wr_beat.data;
        end else begin
            rd_data <= mem[rd_node][rd_idx];
        end
    end

endmodule

`default_nettype wire

/* source/aggr_top.sv */
// aggregation engine top level
`default_nettype none

module aggr_top #(
    parameter int num_banks = 2
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire aggr_pkg::edge_beat_t           edge_in,
    output logic                                edge_ready,
    input  wire                                 rs_ready,
    output aggr_pkg::rs_beat_t                  rs_out,
    input  wire [aggr_pkg::node_id_width-1:0]   rd_node,
    input  wire [aggr_pkg::beat_idx_width-1:0]  rd_idx,
    output aggr_pkg::fv_pair_t                  rd_data
);

    aggr_pkg::edge_beat_t [num_banks-1:0] bank_edge;
    aggr_pkg::rs_beat_t [num_banks-1:0] rs_beats;
    aggr_pkg::sram_beat_t [num_banks-1:0] wb_beats;
    aggr_pkg::sram_beat_t wb_out;
    logic [num_banks-1:0] bank_accept;
    logic [num_banks-1:0] rs_req;
    logic [num_banks-1:0] rs_grant;
    logic [num_banks-1:0] rs_last;
    logic [num_banks-1:0] wb_req;
    logic [num_banks-1:0] wb_grant;
    logic [num_banks-1:0] wb_last;

    edge_dispatch #(
        .num_banks(num_banks)
    ) edge_dispatch_inst (
        .clk(clk),
        .reset(reset),
        .edge_in(edge_in),
        .bank_accept(bank_accept),
        .edge_ready(edge_ready),
        .bank_edge(bank_edge)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        edge_bank edge_bank_inst (
            .clk(clk),
            .reset(reset),
            .edge_in(bank_edge[b]),
            .accept(bank_accept[b]),
            .rs_req(rs_req[b]),
            .rs_grant(rs_grant[b]),
            .rs_beat(rs_beats[b]),
            .wb_req(wb_req[b]),
            .wb_grant(wb_grant[b]),
            .wb_beat(wb_beats[b])
        );

        // release points for the two arbiters
        assign rs_last[b] = rs_beats[b].eos;
        assign wb_last[b] = wb_beats[b].valid
                            && (wb_beats[b].word_idx == aggr_pkg::last_beat_idx);
    end

    bank_arbiter #(
        .num_banks(num_banks),
        .beat_t(aggr_pkg::rs_beat_t)
    ) rs_arbiter_inst (
        .clk(clk),
        .reset(reset),
        .req(rs_req),
        .may_start(rs_ready),
        .last(rs_last),
        .grant(rs_grant),
        .beats_in(rs_beats),
        .beat_out(rs_out)
    );

    // SRAM never stalls, so write-back may always start
    bank_arbiter #(
        .num_banks(num_banks),
        .beat_t(aggr_pkg::sram_beat_t)
    ) wb_arbiter_inst (
        .clk(clk),
        .reset(reset),
        .req(wb_req),
        .may_start(1'b1),
        .last(wb_last),
        .grant(wb_grant),
        .beats_in(wb_beats),
        .beat_out(wb_out)
    );

    output_fv_sram output_fv_sram_inst (
        .clk(clk),
        .wr_beat(wb_out),
        .rd_node(rd_node),
        .rd_idx(rd_idx),
        .rd_data(rd_data)
    );

endmodule

`default_nettype wire

/* bench/aggr_assertions.sv */
// aggregation top level protocol assertions
`default_nettype none

module aggr_assertions #(
    parameter int num_banks = 2
) (
    input wire                                  clk,
    input wire                                  reset,
    input wire                                  edge_ready,
    input wire [num_banks-1:0]                  rs_grant,
    input wire [num_banks-1:0]                  wb_grant,
    input wire aggr_pkg::rs_beat_t [num_banks-1:0] rs_beats,
    input wire aggr_pkg::rs_beat_t              rs_out
);

    int fail_count = 0;

    // each arbiter grants one bank at a time
    rs_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(rs_grant))
    else begin
        fail_count++;
        $error("rs arbiter granted more than one bank");
    end

    wb_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(wb_grant))
    else begin
        fail_count++;
        $error("write-back arbiter granted more than one bank");
    end

    eos_on_valid: assert property (@(posedge clk) disable iff (reset)
        rs_out.eos |-> rs_out.valid)
    else begin
        fail_count++;
        $error("rs_out eos without valid");
    end

    // a bank's rs stream must follow its grant
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        rs_after_grant: assert property (@(posedge clk) disable iff (reset)
            $rose(rs_beats[b].valid) |-> $past(rs_grant[b]))
        else begin
            fail_count++;
            $error("bank %0d drove rs beats without a grant", b);
        end
    end

    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> edge_ready)
    else begin
        fail_count++;
        $error("edge_ready low right after reset");
    end

endmodule

bind aggr_top aggr_assertions #(
    .num_banks(num_banks)
) aggr_assertions_inst (
    .clk(clk),
    .reset(reset),
    .edge_ready(edge_ready),
    .rs_grant(rs_grant),
    .wb_grant(wb_grant),
    .rs_beats(rs_beats),
    .rs_out(rs_out)
);

`default_nettype wire

/* bench/aggr_tb.sv */
// aggregation engine testbench
`default_nettype none

module aggr_tb;

    localparam int num_banks = 2;
    localparam int nid_w = aggr_pkg::node_id_width;
    localparam int num_nodes = 2 ** nid_w;
    localparam int beats = aggr_pkg::max_beats;
    localparam int num_random = 40;
    localparam int num_streams = num_random + 10;

    logic clk;
    logic reset;
    aggr_pkg::edge_beat_t edge_in;
    logic edge_ready;
    logic rs_ready;
    aggr_pkg::rs_beat_t rs_out;
    logic [nid_w-1:0] rd_node;
    logic [aggr_pkg::beat_idx_width-1:0] rd_idx;
    aggr_pkg::fv_pair_t rd_data;

    logic [15:0] lfsr;
    logic rs_random;
    int rs_sent;
    int rs_seen;
    // reference model state, one row per node
    aggr_pkg::fv_pair_t acc [num_nodes][beats];
    aggr_pkg::fv_pair_t sram_exp [num_nodes][beats];
    logic written [num_nodes];
    aggr_pkg::rs_beat_t rs_exp [num_nodes][beats];
    int rs_len [num_nodes];
    logic rs_pending [num_nodes];
    // node still summing in each bank, -1 when free
    int open_node [num_banks];

    aggr_top #(
        .num_banks(num_banks)
    ) aggr_top_inst (
        .clk(clk),
        .reset(reset),
        .edge_in(edge_in),
        .edge_ready(edge_ready),
        .rs_ready(rs_ready),
        .rs_out(rs_out),
        .rd_node(rd_node),
        .rd_idx(rd_idx),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // element-wise sum wrapping at 16 bits
    function automatic aggr_pkg::fv_pair_t add_pair(input aggr_pkg::fv_pair_t a,
                                                    input aggr_pkg::fv_pair_t b);
        aggr_pkg::fv_pair_t s;
        s[0] = a[0] + b[0];
        s[1] = a[1] + b[1];
        return s;
    endfunction

    task automatic fail_now(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_rs_beat(input aggr_pkg::rs_beat_t got, input aggr_pkg::rs_beat_t exp);
        if (got !== exp) begin
            fail_now($sformatf("rs beat node %0d got %h expected %h", exp.node_id, got, exp));
        end
    endtask

    task automatic check_rd_data(input aggr_pkg::fv_pair_t got, input aggr_pkg::fv_pair_t exp,
                                 input int node, input int k);
        if (got !== exp) begin
            fail_now($sformatf("sram node %0d pair %0d got %h expected %h", node, k, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("%s is %b, expected %b", what, got, exp));
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if (rs_random) begin
            rs_ready = (rand_bits(1) != 0);
        end
    endtask

    // cmd 0 plain end, 1 write-back, 2 done-aggregation
    task automatic send_stream(input int node, input int len, input int cmd);
        aggr_pkg::edge_beat_t beat;
        logic taken;
        for (int k = 0; k < len; k++) begin
            beat = '0;
            beat.valid = 1'b1;
            beat.sos = (k == 0);
            beat.eos = (k == len - 1);
            beat.wb_en = (k == len - 1) && (cmd == 1);
            beat.done_aggr = (k == len - 1) && (cmd == 2);
            beat.node_id = nid_w'(node);
            beat.data = rand_bits(32);
            edge_in = beat;
            taken = 1'b0;
            while (!taken) begin
                @(posedge clk);
                taken = edge_ready;
                next_cycle();
            end
            acc[node][k] = add_pair(acc[node][k], beat.data);
        end
        edge_in.valid = 1'b0;
        open_node[node % num_banks] = (cmd == 0) ? node : -1;
        if (cmd == 2) begin
            for (int k = 0; k < len; k++) begin
                rs_exp[node][k] = '0;
                rs_exp[node][k].valid = 1'b1;
                rs_exp[node][k].sos = (k == 0);
                rs_exp[node][k].eos = (k == len - 1);
                rs_exp[node][k].node_id = nid_w'(node);
                rs_exp[node][k].data = acc[node][k];
            end
            rs_len[node] = len;
            rs_pending[node] = 1'b1;
            rs_sent++;
        end else if (cmd == 1) begin
            sram_exp[node] = acc[node];
            written[node] = 1'b1;
        end
        if (cmd != 0) begin
            for (int k = 0; k < beats; k++) begin
                acc[node][k] = '0;
            end
        end
    endtask

    task automatic drain_rs();
        while (rs_seen != rs_sent) begin
            next_cycle();
        end
    endtask

    // an idle bank accepts again, so its write-back has landed
    task automatic wait_idle(input int bank);
        logic ready;
        edge_in.node_id = nid_w'(bank);
        ready = 1'b0;
        while (!ready) begin
            @(posedge clk);
            ready = edge_ready;
            next_cycle();
        end
    endtask

    task automatic read_check(input int node);
        for (int k = 0; k < beats; k++) begin
            rd_node = nid_w'(node);
            rd_idx = k[aggr_pkg::beat_idx_width-1:0];
            next_cycle();
            check_rd_data(rd_data, sram_exp[node][k], node, k);
        end
    endtask

    // compares every rs_out beat against the model
    initial begin : rs_monitor
        int node;
        int k;
        node = 0;
        k = 0;
        forever begin
            @(negedge clk);
            if (rs_out.valid === 1'b1) begin
                if (k == 0) begin
                    node = rs_out.node_id;
                    if (!rs_pending[node]) begin
                        fail_now($sformatf("rs stream for node %0d that has no result due", node));
                    end
                end
                check_rs_beat(rs_out, rs_exp[node][k]);
                k++;
                if (k == rs_len[node]) begin
                    rs_pending[node] = 1'b0;
                    rs_seen++;
                    k = 0;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (200 * num_streams) @(posedge clk);
        $display("simulation timed out after %0d cycles", 200 * num_streams);
        $display("TEST FAIL");
        $fatal(1);
    end

    initial begin
        int node;
        reset = 1'b1;
        edge_in = '0;
        rs_ready = 1'b1;
        rd_node = '0;
        rd_idx = '0;
        lfsr = 16'd25722;
        rs_random = 1'b0;
        rs_sent = 0;
        rs_seen = 0;
        for (int n = 0; n < num_nodes; n++) begin
            written[n] = 1'b0;
            rs_pending[n] = 1'b0;
            rs_len[n] = 0;
            for (int k = 0; k < beats; k++) begin
                acc[n][k] = '0;
                sram_exp[n][k] = '0;
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            open_node[b] = -1;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        next_cycle();
        check_flag(edge_ready, 1'b1, "edge_ready after reset");
        check_flag(rs_out.valid, 1'b0, "rs_out.valid after reset");

        // single done-aggregation
        send_stream(5, rand_bits(2) + 1, 2);
        drain_rs();

        // accumulation, then a fresh node on the same bank
        for (int i = 0; i < 3; i++) begin
            send_stream(9, rand_bits(2) + 1, 0);
        end
        send_stream(9, rand_bits(2) + 1, 2);
        send_stream(11, rand_bits(2) + 1, 2);
        drain_rs();

        // write-back into the SRAM
        send_stream(20, rand_bits(2) + 1, 0);
        send_stream(20, rand_bits(2) + 1, 1);
        wait_idle(0);
        read_check(20);

        // random traffic with rs_ready toggling
        rs_random = 1'b1;
        for (int i = 0; i < num_random; i++) begin
            node = rand_bits(nid_w);
            if (open_node[node % num_banks] >= 0) begin
                node = open_node[node % num_banks];
            end
            send_stream(node, rand_bits(2) + 1, (rand_bits(2) < 2) ? 0 : rand_bits(2) % 2 + 1);
        end
        for (int b = 0; b < num_banks; b++) begin
            if (open_node[b] >= 0) begin
                send_stream(open_node[b], rand_bits(2) + 1, 2);
            end
        end
        rs_random = 1'b0;
        rs_ready = 1'b1;
        drain_rs();
        for (int b = 0; b < num_banks; b++) begin
            wait_idle(b);
        end
        for (int n = 0; n < num_nodes; n++) begin
            if (written[n]) begin
                read_check(n);
            end
        end

        if (aggr_top_inst.aggr_assertions_inst.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* all.f */
source/aggr_pkg.sv
source/edge_dispatch.sv
source/edge_bank.sv
source/bank_arbiter.sv
source/output_fv_sram.sv
source/aggr_top.sv
bench/aggr_assertions.sv
bench/aggr_tb.sv

/* Bender.yml */
package:
  name: aggr_engine

sources:
  - files:
      - source/aggr_pkg.sv
      - source/edge_dispatch.sv
      - source/edge_bank.sv
      - source/bank_arbiter.sv
      - source/output_fv_sram.sv
      - source/aggr_top.sv
  - target: test
    files:
      - bench/aggr_assertions.sv
      - bench/aggr_tb.sv
